// ==== all.f ====
design/axi_bridge_pkg.sv
design/mux_1h.sv
design/axi_wr.sv
design/axi_rd.sv
design/axi_bridge.sv
testbench/tb_clock.sv
testbench/axi_mem_model.sv
testbench/axi_bridge_tb.sv

// ==== design/axi_bridge.sv ====
module axi_bridge (
    input  logic clk,
    input  logic reset,

    // cache write side
    input  logic wr_req,
    input  axi_bridge_pkg::cache_wr_t wr,
    output logic wr_rdy,

    // cache read side
    input  logic rd_req,
    input  axi_bridge_pkg::cache_rd_t rd,
    output logic rd_rdy,
    output logic ret_valid,
    output axi_bridge_pkg::axi_r_t ret,

    // aw
    output axi_bridge_pkg::axi_addr_t aw,
    output logic awvalid,
    input  logic awready,

    // w
    output axi_bridge_pkg::axi_w_t w,
    output logic wvalid,
    input  logic wready,

    // b
    input  logic bvalid,
    output logic bready,

    // ar
    output axi_bridge_pkg::axi_addr_t ar,
    output logic arvalid,
    input  logic arready,

    // r
    input  axi_bridge_pkg::axi_r_t r,
    input  logic rvalid,
    output logic rready
);

    logic read_unfinish;
    logic wr_idle;

    axi_wr axi_wr_i (
        .clk(clk),
        .reset(reset),
        .wr_req(wr_req),
        .wr(wr),
        .wr_rdy(wr_rdy),
        .read_unfinish(read_unfinish),
        .wr_idle(wr_idle),
        .aw(aw),
        .awvalid(awvalid),
        .awready(awready),
        .w(w),
        .wvalid(wvalid),
        .wready(wready),
        .bvalid(bvalid),
        .bready(bready)
    );

    axi_rd axi_rd_i (
        .clk(clk),
        .reset(reset),
        .rd_req(rd_req),
        .rd(rd),
        .rd_rdy(rd_rdy),
        .ret_valid(ret_valid),
        .ret(ret),
        .wr_idle(wr_idle),
        .read_unfinish(read_unfinish),
        .ar(ar),
        .arvalid(arvalid),
        .arready(arready),
        .rvalid(rvalid),
        .r(r),
        .rready(rready)
    );

endmodule

// ==== design/axi_bridge_pkg.sv ====
package axi_bridge_pkg;

    // line geometry
    localparam int bytes_per_line = 16;
    localparam int words_per_line = bytes_per_line / 4;
    localparam int line_width = words_per_line * 32;
    localparam int ptr_width = $clog2(words_per_line);

    // axi encodings
    localparam logic [7:0] burst_len = 8'(words_per_line - 1);
    localparam logic [1:0] burst_fixed = 2'b00;
    localparam logic [1:0] burst_incr = 2'b01;
    localparam logic [2:0] size_word = 3'b010;

    // write engine states
    localparam int ws_width = 3;
    localparam logic [ws_width-1:0] ws_idle = 3'd0;
    localparam logic [ws_width-1:0] ws_aw_w = 3'd1;
    localparam logic [ws_width-1:0] ws_aw = 3'd2;
    localparam logic [ws_width-1:0] ws_w = 3'd3;
    localparam logic [ws_width-1:0] ws_wait = 3'd4;

    // read engine states
    localparam int rs_width = 2;
    localparam logic [rs_width-1:0] rs_idle = 2'd0;
    localparam logic [rs_width-1:0] rs_addr = 2'd1;
    localparam logic [rs_width-1:0] rs_data = 2'd2;

    typedef struct packed {
        logic burst;
        logic [31:0] addr;
        logic [1:0] size;
        logic [3:0] strb;
        logic [line_width-1:0] data;
    } cache_wr_t;

    typedef struct packed {
        logic burst;
        logic [31:0] addr;
        logic [1:0] size;
    } cache_rd_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
    } axi_addr_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0] strb;
        logic last;
    } axi_w_t;

    typedef struct packed {
        logic [31:0] data;
        logic last;
    } axi_r_t;

endpackage

// ==== design/axi_rd.sv ====
module axi_rd (
    input  logic clk,
    input  logic reset,

    // cache side
    input  logic rd_req,
    input  axi_bridge_pkg::cache_rd_t rd,
    output logic rd_rdy,
    output logic ret_valid,
    output axi_bridge_pkg::axi_r_t ret,

    // coupling with the write engine
    input  logic wr_idle,
    output logic read_unfinish,

    // ar
    output axi_bridge_pkg::axi_addr_t ar,
    output logic arvalid,
    input  logic arready,

    // r
    input  logic rvalid,
    input  axi_bridge_pkg::axi_r_t r,
    output logic rready
);
    import axi_bridge_pkg::*;

    cache_rd_t req;

    logic [rs_width-1:0] state;
    logic [rs_width-1:0] state_next;

    logic state_idle;
    logic state_addr;
    logic state_data;

    logic ar_handshake;
    logic r_finish;

    logic idle_to_idle;
    logic idle_to_addr;
    logic addr_to_addr;
    logic addr_to_data;
    logic data_to_data;
    logic data_to_idle;

    assign state_idle = (state == rs_idle);
    assign state_addr = (state == rs_addr);
    assign state_data = (state == rs_data);

    assign ar_handshake = arvalid & arready;
    assign r_finish = rvalid & r.last;

    assign idle_to_addr = state_idle & rd_req;
    assign idle_to_idle = state_idle & ~rd_req;

    assign addr_to_data = state_addr & ar_handshake;
    assign addr_to_addr = state_addr & ~ar_handshake;

    assign data_to_idle = state_data & r_finish;
    assign data_to_data = state_data & ~r_finish;

    mux_1h #(
        .num_port(3),
        .data_width(rs_width)
    ) next_mux (
        .select({
            idle_to_idle | data_to_idle,
            idle_to_addr | addr_to_addr,
            addr_to_data | data_to_data
        }),
        .in({rs_idle, rs_addr, rs_data}),
        .out(state_next)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= rs_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (idle_to_addr) begin
            req <= rd;
        end
    end

    // line fill or single word
    always_comb begin
        if (req.burst) begin
            ar = '{addr: req.addr, len: burst_len, size: size_word, burst: burst_incr};
        end else begin
            ar = '{addr: req.addr, len: 8'd0, size: {1'b0, req.size}, burst: burst_fixed};
        end
    end

    // hold off until earlier writes have drained
    assign arvalid = state_addr & wr_idle;

    assign rd_rdy = state_idle;
    assign read_unfinish = ~state_idle;

    assign rready = 1'b1;

    // return path is unregistered
    assign ret_valid = state_data & rvalid;
    assign ret = r;

endmodule

// ==== design/axi_wr.sv ====
module axi_wr (
    input  logic clk,
    input  logic reset,

    // cache side
    input  logic wr_req,
    input  axi_bridge_pkg::cache_wr_t wr,
    output logic wr_rdy,

    // coupling with the read engine
    input  logic read_unfinish,
    output logic wr_idle,

    // aw
    output axi_bridge_pkg::axi_addr_t aw,
    output logic awvalid,
    input  logic awready,

    // w
    output axi_bridge_pkg::axi_w_t w,
    output logic wvalid,
    input  logic wready,

    // b
    input  logic bvalid,
    output logic bready
);
    import axi_bridge_pkg::*;

    cache_wr_t wbuf;
    logic buf_empty;
    logic wr_younger;
    logic [ptr_width-1:0] ptr;

    logic [ws_width-1:0] state;
    logic [ws_width-1:0] state_next;

    logic state_idle;
    logic state_aw_w;
    logic state_aw;
    logic state_w;
    logic state_wait;

    logic w_last;
    logic w_handshake;
    logic w_finish;

    logic [2:0] sel_size;
    logic [1:0] sel_burst;
    logic [7:0] sel_len;
    logic [3:0] sel_strb;

    assign state_idle = (state == ws_idle);
    assign state_aw_w = (state == ws_aw_w);
    assign state_aw = (state == ws_aw);
    assign state_w = (state == ws_w);
    assign state_wait = (state == ws_wait);

    // single writes are always one beat
    assign w_last = wbuf.burst ? (&ptr) : 1'b1;
    assign w_handshake = wvalid & wready;
    assign w_finish = w_last & w_handshake;

    // transitions
    logic idle_to_aw_w;
    logic idle_to_idle;
    logic aw_w_to_wait;
    logic aw_w_to_aw;
    logic aw_w_to_w;
    logic aw_w_to_aw_w;
    logic aw_to_wait;
    logic aw_to_aw;
    logic w_to_wait;
    logic w_to_w;
    logic wait_to_idle;
    logic wait_to_wait;
    logic enter_wait;

    assign idle_to_aw_w = state_idle & ~buf_empty & ~(read_unfinish & wr_younger);
    assign idle_to_idle = state_idle & ~idle_to_aw_w;

    assign aw_w_to_wait = state_aw_w & w_finish & awready;
    assign aw_w_to_aw = state_aw_w & w_finish & ~awready;
    assign aw_w_to_w = state_aw_w & ~w_finish & awready;
    assign aw_w_to_aw_w = state_aw_w & ~w_finish & ~awready;

    assign aw_to_wait = state_aw & awready;
    assign aw_to_aw = state_aw & ~awready;

    assign w_to_wait = state_w & w_finish;
    assign w_to_w = state_w & ~w_finish;

    assign wait_to_idle = state_wait & bvalid;
    assign wait_to_wait = state_wait & ~bvalid;

    assign enter_wait = aw_w_to_wait | aw_to_wait | w_to_wait;

    mux_1h #(
        .num_port(5),
        .data_width(ws_width)
    ) next_mux (
        .select({
            idle_to_idle | wait_to_idle,
            idle_to_aw_w | aw_w_to_aw_w,
            aw_w_to_aw | aw_to_aw,
            aw_w_to_w | w_to_w,
            enter_wait | wait_to_wait
        }),
        .in({ws_idle, ws_aw_w, ws_aw, ws_w, ws_wait}),
        .out(state_next)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ws_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_req) begin
            wbuf <= wr;
        end
    end

    // a write accepted while a read is pending is younger than that read
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_younger <= 1'b0;
        end else if (wr_req) begin
            wr_younger <= read_unfinish;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (wr_req) begin
            ptr <= '0;
        end else if (w_handshake) begin
            ptr <= ptr + 1'b1;
        end
    end

    // buffer frees once both aw and the last w beat are done
    always_ff @(posedge clk) begin
        if (reset) begin
            buf_empty <= 1'b1;
        end else if (wr_req) begin
            buf_empty <= 1'b0;
        end else if (enter_wait) begin
            buf_empty <= 1'b1;
        end
    end

    // burst vs single field choice
    mux_1h #(
        .num_port(2),
        .data_width(3 + 2 + 8 + 4)
    ) field_mux (
        .select({wbuf.burst, ~wbuf.burst}),
        .in({
            {size_word, burst_incr, burst_len, 4'b1111},
            {{1'b0, wbuf.size}, burst_fixed, 8'd0, wbuf.strb}
        }),
        .out({sel_size, sel_burst, sel_len, sel_strb})
    );

    assign wr_rdy = buf_empty | enter_wait;

    // a younger write held in the buffer lets the pending read go first
    assign wr_idle = state_idle & (buf_empty | (wr_younger & read_unfinish));

    assign aw = '{addr: wbuf.addr, len: sel_len, size: sel_size, burst: sel_burst};
    assign awvalid = state_aw_w | state_aw;

    assign w = '{data: wbuf.data[ptr*32 +: 32], strb: sel_strb, last: w_last};
    assign wvalid = state_aw_w | state_w;

    assign bready = 1'b1;

endmodule

// ==== design/mux_1h.sv ====
module mux_1h #(
    parameter int num_port = 2,
    parameter int data_width = 1
) (
    input  logic [num_port-1:0] select,
    input  logic [num_port*data_width-1:0] in,
    output logic [data_width-1:0] out
);

    // select is one-hot, so an OR of the enabled slices is enough
    always_comb begin
        out = '0;
        for (int i = 0; i < num_port; i++) begin
            if (select[i]) begin
                out = out | in[i*data_width +: data_width];
            end
        end
    end

endmodule

// ==== testbench/axi_bridge_tb.sv ====
module axi_bridge_tb;
    import axi_bridge_pkg::*;

    localparam int max_tests = 64;
    localparam int fields = 6;
    localparam int cycles_per_test = 400;

    localparam logic [31:0] op_write_line = 32'd1;
    localparam logic [31:0] op_write_word = 32'd2;
    localparam logic [31:0] op_read_line = 32'd3;
    localparam logic [31:0] op_read_word = 32'd4;

    typedef struct packed {
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] a0;
        logic [31:0] a1;
        logic [31:0] a2;
        logic [31:0] a3;
    } test_line_t;

    logic clk;
    logic reset;

    logic wr_req;
    cache_wr_t wr;
    logic wr_rdy;
    logic rd_req;
    cache_rd_t rd;
    logic rd_rdy;
    logic ret_valid;
    axi_r_t ret;

    axi_addr_t aw;
    logic awvalid;
    logic awready;
    axi_w_t w;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic bready;
    axi_addr_t ar;
    logic arvalid;
    logic arready;
    axi_r_t r;
    logic rvalid;
    logic rready;

    logic [31:0] test_words [0:max_tests*fields-1];
    int num_tests;
    int cycle_limit;
    int cycles;
    logic [31:0] exp_data [$];
    logic exp_last [$];

    tb_clock #(.period(100)) clock_i (.clk(clk));

    axi_bridge axi_bridge_i (
        .clk(clk),
        .reset(reset),
        .wr_req(wr_req),
        .wr(wr),
        .wr_rdy(wr_rdy),
        .rd_req(rd_req),
        .rd(rd),
        .rd_rdy(rd_rdy),
        .ret_valid(ret_valid),
        .ret(ret),
        .aw(aw),
        .awvalid(awvalid),
        .awready(awready),
        .w(w),
        .wvalid(wvalid),
        .wready(wready),
        .bvalid(bvalid),
        .bready(bready),
        .ar(ar),
        .arvalid(arvalid),
        .arready(arready),
        .r(r),
        .rvalid(rvalid),
        .rready(rready)
    );

    axi_mem_model mem_i (
        .clk(clk),
        .reset(reset),
        .aw(aw),
        .awvalid(awvalid),
        .awready(awready),
        .w(w),
        .wvalid(wvalid),
        .wready(wready),
        .bvalid(bvalid),
        .bready(bready),
        .ar(ar),
        .arvalid(arvalid),
        .arready(arready),
        .r(r),
        .rvalid(rvalid),
        .rready(rready)
    );

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic load_tests();
        for (int i = 0; i < max_tests * fields; i++) begin
            test_words[i] = '0;
        end
        $readmemh("testbench/axi_bridge_tests.txt", test_words);
        num_tests = 0;
        while (num_tests < max_tests && test_words[num_tests * fields] != 0) begin
            num_tests++;
        end
        if (num_tests == 0) begin
            $display("no test lines could be read from the tests file");
            abort_run();
        end
        cycle_limit = num_tests * cycles_per_test;
    endtask

    task automatic issue_write(input test_line_t t, input logic line);
        cache_wr_t req;
        @(negedge clk);
        while (!wr_rdy) begin
            @(negedge clk);
        end
        req.burst = line;
        req.addr = t.addr;
        req.size = 2'b10;
        req.strb = line ? 4'b1111 : t.a0[3:0];
        req.data = line ? {t.a3, t.a2, t.a1, t.a0} : {{(line_width - 32){1'b0}}, t.a1};
        @(posedge clk);
        wr_req <= 1'b1;
        wr <= req;
        @(posedge clk);
        wr_req <= 1'b0;
    endtask

    task automatic issue_read(input test_line_t t, input logic line);
        cache_rd_t req;
        @(negedge clk);
        while (!rd_rdy) begin
            @(negedge clk);
        end
        req.burst = line;
        req.addr = t.addr;
        req.size = 2'b10;
        // words come back in address order
        exp_data.push_back(t.a0);
        exp_last.push_back(~line);
        if (line) begin
            exp_data.push_back(t.a1);
            exp_last.push_back(1'b0);
            exp_data.push_back(t.a2);
            exp_last.push_back(1'b0);
            exp_data.push_back(t.a3);
            exp_last.push_back(1'b1);
        end
        @(posedge clk);
        rd_req <= 1'b1;
        rd <= req;
        @(posedge clk);
        rd_req <= 1'b0;
    endtask

    always @(negedge clk) begin
        if (!reset && ret_valid) begin
            if (exp_data.size() == 0) begin
                $display("read data came back with no read outstanding at %0t", $time);
                abort_run();
            end else begin
                check_value(ret.data, exp_data.pop_front(), "read data");
                check_value(32'(ret.last), 32'(exp_last.pop_front()), "ret.last");
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout, the run did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    initial begin : run
        test_line_t t;
        reset = 1'b1;
        wr_req = 1'b0;
        wr = '0;
        rd_req = 1'b0;
        rd = '0;
        load_tests();
        repeat (4) begin
            @(posedge clk);
        end
        reset <= 1'b0;

        // nothing may start before the first request
        repeat (3) begin
            @(negedge clk);
            check_value(32'(awvalid), 32'd0, "awvalid after reset");
            check_value(32'(wvalid), 32'd0, "wvalid after reset");
            check_value(32'(arvalid), 32'd0, "arvalid after reset");
            check_value(32'(wr_rdy), 32'd1, "wr_rdy after reset");
            check_value(32'(rd_rdy), 32'd1, "rd_rdy after reset");
        end

        for (int n = 0; n < num_tests; n++) begin
            t = {test_words[n*fields], test_words[n*fields + 1], test_words[n*fields + 2],
                 test_words[n*fields + 3], test_words[n*fields + 4], test_words[n*fields + 5]};
            case (t.op)
                op_write_line: issue_write(t, 1'b1);
                op_write_word: issue_write(t, 1'b0);
                op_read_line: issue_read(t, 1'b1);
                op_read_word: issue_read(t, 1'b0);
                default: begin
                    $display("unknown operation %0d on test line %0d", t.op, n);
                    abort_run();
                end
            endcase
        end

        // drain the last read
        @(negedge clk);
        while (exp_data.size() != 0 || !rd_rdy || !wr_rdy) begin
            @(negedge clk);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== testbench/axi_bridge_tests.txt ====
// op addr a0 a1 a2 a3: op 1 write line (a0..a3 data), 2 write word (a0 strobe, a1 data)
// op 3 read line (a0..a3 expected words), 4 read word (a0 expected), unused columns are 0
1 00000000 a0a0a0a0 a1a1a1a1 a2a2a2a2 a3a3a3a3
3 00000000 a0a0a0a0 a1a1a1a1 a2a2a2a2 a3a3a3a3
1 00000040 11223344 55667788 99aabbcc ddeeff00
2 00000044 00000003 0000cafe 00000000 00000000
2 00000048 0000000c beef0000 00000000 00000000
4 00000044 5566cafe 00000000 00000000 00000000
2 0000004c 00000009 12345678 00000000 00000000
2 00000040 0000000f 0badf00d 00000000 00000000
3 00000040 0badf00d 5566cafe beefbbcc 12eeff78
1 00000100 01010101 02020202 03030303 04040404
3 00000100 01010101 02020202 03030303 04040404
2 00000104 00000006 00abcd00 00000000 00000000
4 00000104 02abcd02 00000000 00000000 00000000
3 00000000 a0a0a0a0 a1a1a1a1 a2a2a2a2 a3a3a3a3
1 00000000 f0f0f0f0 f1f1f1f1 f2f2f2f2 f3f3f3f3
1 00000200 76543210 fedcba98 13579bdf 02468ace
1 00000210 c001d00d 600dcafe 8badf00d 0d15ea5e
1 000003f0 31415926 27182818 16180339 14142135
2 000003fc 0000000f 5a5a5a5a 00000000 00000000
3 00000000 f0f0f0f0 f1f1f1f1 f2f2f2f2 f3f3f3f3
3 00000040 0badf00d 5566cafe beefbbcc 12eeff78
3 00000100 01010101 02abcd02 03030303 04040404
3 00000200 76543210 fedcba98 13579bdf 02468ace
3 00000210 c001d00d 600dcafe 8badf00d 0d15ea5e
3 000003f0 31415926 27182818 16180339 5a5a5a5a
4 000003fc 5a5a5a5a 00000000 00000000 00000000

// ==== testbench/axi_mem_model.sv ====
module axi_mem_model (
    input  logic clk,
    input  logic reset,
    input  axi_bridge_pkg::axi_addr_t aw,
    input  logic awvalid,
    output logic awready,
    input  axi_bridge_pkg::axi_w_t w,
    input  logic wvalid,
    output logic wready,
    output logic bvalid,
    input  logic bready,
    input  axi_bridge_pkg::axi_addr_t ar,
    input  logic arvalid,
    output logic arready,
    output axi_bridge_pkg::axi_r_t r,
    output logic rvalid,
    input  logic rready
);
    import axi_bridge_pkg::*;

    logic [31:0] mem [0:255];
    logic [31:0] lfsr;

    axi_addr_t aw_q;
    logic aw_got;
    logic [31:0] w_data [0:words_per_line-1];
    logic [3:0] w_strb [0:words_per_line-1];
    int w_cnt;
    logic w_done;
    logic b_pend;
    int b_delay;

    axi_addr_t ar_q;
    logic rd_active;
    int rd_beat;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [3:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[2:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic logic [7:0] beat_index(input axi_addr_t a, input int beat);
        logic [31:0] byte_addr;
        byte_addr = (a.burst == burst_incr) ? a.addr + 32'(beat * 4) : a.addr;
        return byte_addr[9:2];
    endfunction

    initial begin
        lfsr = 32'h8080;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {~i[7:0], i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
        end
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        arready = 1'b0;
        rvalid = 1'b0;
        r = '0;
    end

    always @(posedge clk) begin : slave
        logic [3:0] bits;
        logic [31:0] word;
        logic [7:0] idx;
        if (reset) begin
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            arready <= 1'b0;
            rvalid <= 1'b0;
            aw_got <= 1'b0;
            w_cnt <= 0;
            w_done <= 1'b0;
            b_pend <= 1'b0;
            rd_active <= 1'b0;
        end else begin
            take_bits(3, bits);
            awready <= bits[0];
            wready <= bits[1];
            arready <= bits[2] & ~rd_active;

            if (awvalid && awready) begin
                aw_q <= aw;
                aw_got <= 1'b1;
            end
            if (wvalid && wready) begin
                w_data[w_cnt] <= w.data;
                w_strb[w_cnt] <= w.strb;
                w_cnt <= w_cnt + 1;
                if (w.last) begin
                    w_done <= 1'b1;
                end
            end

            // commit once the address and every beat are in
            if (aw_got && w_done) begin
                for (int i = 0; i < w_cnt; i++) begin
                    idx = beat_index(aw_q, i);
                    word = mem[idx];
                    for (int b = 0; b < 4; b++) begin
                        if (w_strb[i][b]) begin
                            word[8*b +: 8] = w_data[i][8*b +: 8];
                        end
                    end
                    mem[idx] = word;
                end
                aw_got <= 1'b0;
                w_done <= 1'b0;
                w_cnt <= 0;
                take_bits(2, bits);
                b_delay <= bits[1:0];
                b_pend <= 1'b1;
            end

            if (bvalid && bready) begin
                bvalid <= 1'b0;
                b_pend <= 1'b0;
            end else if (b_pend && !bvalid) begin
                if (b_delay == 0) begin
                    bvalid <= 1'b1;
                end else begin
                    b_delay <= b_delay - 1;
                end
            end

            if (arvalid && arready) begin
                ar_q <= ar;
                rd_active <= 1'b1;
                rd_beat <= 0;
            end
            if (rd_active) begin
                if (rvalid && rready) begin
                    rvalid <= 1'b0;
                    if (r.last) begin
                        rd_active <= 1'b0;
                    end else begin
                        rd_beat <= rd_beat + 1;
                    end
                end else if (!rvalid) begin
                    // random gap before each beat
                    take_bits(1, bits);
                    if (bits[0]) begin
                        rvalid <= 1'b1;
                        r <= '{data: mem[beat_index(ar_q, rd_beat)],
                               last: (rd_beat == int'(ar_q.len))};
                    end
                end
            end
        end
    end

endmodule

// ==== testbench/tb_clock.sv ====
module tb_clock #(
    parameter int period = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2);
            clk = ~clk;
        end
    end

endmodule
